/* Makefile */
# Verilator build and run of the data memory testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mem_subsys
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# the run passes only if the testbench printed its pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(OBJ_DIR)

/* data_ram.sv */
`timescale 1ns/1ns

module data_ram (
    input  logic               clk,
    input  mem_pkg::mem_req_t  req,
    output mem_pkg::mem_word_u rdata
);

    import mem_pkg::*;

    // no reset and no initial contents, bytes are unknown until written
    logic [7:0] mem [mem_bytes];

    // byte address of every lane of the word at req.addr
    logic [word_bytes-1:0][addr_w-1:0] lane_addr;

    // ========================================================================
    // lane addressing
    // ========================================================================

    // the add is addr_w wide, so the upper lanes of a word near the top of
    // memory fold back to address 0 and up
    for (genvar k = 0; k < word_bytes; k++) begin : g_lane
        assign lane_addr[k] = req.addr + addr_w'(k);
    end

    // ========================================================================
    // read port
    // ========================================================================

    // combinational, lane 0 is also the byte read
    always_comb begin
        for (int k = 0; k < word_bytes; k++) begin
            rdata.bytes[k] = mem[lane_addr[k]];
        end
    end

    // ========================================================================
    // write port
    // ========================================================================

    always_ff @(posedge clk) begin
        if (req.we) begin
            if (req.is_word) begin
                // little endian, lane k lands at addr + k
                for (int k = 0; k < word_bytes; k++) begin
                    mem[lane_addr[k]] <= req.wdata.bytes[k];
                end
            end else begin
                mem[lane_addr[0]] <= req.wdata.bytes[0];
            end
        end
    end

endmodule

/* files.f */
mem_pkg.sv
lsu_issue.sv
data_ram.sv
load_align.sv
mem_subsys.sv
tb_mem_subsys.sv

/* load_align.sv */
`timescale 1ns/1ns

module load_align (
    input  logic               clk,
    input  logic               rst,
    input  mem_pkg::load_ctl_t ctl,
    input  mem_pkg::mem_word_u rdata,
    output logic               load_valid,
    output logic [31:0]        load_data
);

    import mem_pkg::*;

    logic [7:0]  load_byte;
    logic        fill_bit;
    logic [31:0] ext_data;

    // ========================================================================
    // extension
    // ========================================================================

    // a byte load always comes from lane 0, the byte at the request address
    assign load_byte = rdata.bytes[0];

    // upper bits copy bit 7 for a signed byte and are zero otherwise
    assign fill_bit = ctl.is_signed && load_byte[7];

    always_comb begin
        if (ctl.is_word) begin
            ext_data = rdata.word;
        end else begin
            ext_data = {{24{fill_bit}}, load_byte};
        end
    end

    // ========================================================================
    // result register
    // ========================================================================

    // load_valid is high for exactly one cycle per load, nothing is held
    always_ff @(posedge clk) begin
        load_data <= ext_data;

        if (rst) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= ctl.valid;
        end
    end

endmodule

/* lsu_issue.sv */
`timescale 1ns/1ns

module lsu_issue (
    input  logic               clk,
    input  logic               rst,
    input  logic               cmd_valid,
    input  mem_pkg::lsu_cmd_t  cmd,
    output mem_pkg::mem_req_t  req,
    output mem_pkg::load_ctl_t ctl
);

    import mem_pkg::*;

    logic [31:0] offset_ext;
    logic [31:0] eff_addr;
    logic        is_load;

    // ========================================================================
    // effective address
    // ========================================================================

    // the displacement is signed, so a negative offset steps back from base
    assign offset_ext = {{(32 - offset_w){cmd.offset[offset_w-1]}}, cmd.offset};

    // only the low addr_w bits reach the RAM, which gives the modulo wrap
    assign eff_addr = cmd.base + offset_ext;

    assign is_load = cmd_valid && !cmd.is_store;

    // ========================================================================
    // request and load control registers
    // ========================================================================

    // request and control are loaded on the same edge so they stay paired
    always_ff @(posedge clk) begin
        req.is_word   <= cmd.is_word;
        req.addr      <= eff_addr[addr_w-1:0];
        req.wdata     <= cmd.wdata;
        ctl.is_word   <= cmd.is_word;
        ctl.is_signed <= cmd.is_signed;

        if (rst) begin
            req.we    <= 1'b0;
            ctl.valid <= 1'b0;
        end else begin
            // an idle cycle leaves both strobes low
            req.we    <= cmd_valid && cmd.is_store;
            ctl.valid <= is_load;
        end
    end

endmodule

/* mem_pkg.sv */
package mem_pkg;

    // ========================================================================
    // memory geometry
    // ========================================================================

    // data RAM size in bytes, addresses wrap modulo this value
    localparam int mem_bytes = 32;

    localparam int addr_w = $clog2(mem_bytes);

    // signed displacement carried by a load/store command
    localparam int offset_w = 12;

    // bytes per data word, lane 0 sits at the lowest address
    localparam int word_bytes = 4;

    // ========================================================================
    // shared types
    // ========================================================================

    // one data word, seen either whole or as little-endian byte lanes
    typedef union packed {
        logic [31:0]                word;
        logic [word_bytes-1:0][7:0] bytes;
    } mem_word_u;

    // command as it arrives at the issue stage
    typedef struct packed {
        logic                is_store;
        logic                is_word;
        logic                is_signed;
        logic [31:0]         base;
        logic [offset_w-1:0] offset;
        mem_word_u           wdata;
    } lsu_cmd_t;

    // request presented to the data RAM
    typedef struct packed {
        logic              we;
        logic              is_word;
        logic [addr_w-1:0] addr;
        mem_word_u         wdata;
    } mem_req_t;

    // load control, travels beside the request into the aligner
    typedef struct packed {
        logic valid;
        logic is_word;
        logic is_signed;
    } load_ctl_t;

endpackage

/* mem_subsys.sv */
`timescale 1ns/1ns

module mem_subsys (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_valid,
    input  mem_pkg::lsu_cmd_t cmd,
    output logic              load_valid,
    output logic [31:0]       load_data
);

    import mem_pkg::*;

    // ========================================================================
    // internal wiring
    // ========================================================================

    mem_req_t  req;
    load_ctl_t ctl;
    mem_word_u rdata;

    // issue stage, one request per command
    lsu_issue i_lsu_issue (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .req       (req),
        .ctl       (ctl)
    );

    // a store on this request is written on the same edge that registers
    // the data of a load on it
    data_ram i_data_ram (
        .clk   (clk),
        .req   (req),
        .rdata (rdata)
    );

    // ctl skips the RAM and meets its read data here
    load_align i_load_align (
        .clk        (clk),
        .rst        (rst),
        .ctl        (ctl),
        .rdata      (rdata),
        .load_valid (load_valid),
        .load_data  (load_data)
    );

endmodule

/* tb_mem_subsys.sv */
`timescale 1ns/1ns

module tb_mem_subsys;

    import mem_pkg::*;

    localparam int          clk_period    = 10;
    localparam int unsigned seed          = 32'hffcde7cc;
    localparam int          reset_cycles  = 2;
    localparam int          directed_cmds = 64;
    localparam int          random_cmds   = 600;
    localparam int          margin_cycles = 50;
    localparam int          timeout_ns    =
        (reset_cycles + directed_cmds + random_cmds + margin_cycles) * clk_period;

    logic        clk;
    logic        rst;
    logic        cmd_valid;
    lsu_cmd_t    cmd;
    logic        load_valid;
    logic [31:0] load_data;

    // reference copy of the data RAM that is updated in command order
    logic [7:0]  ref_mem [mem_bytes];
    logic [31:0] exp_q [$];

    // expected valid pattern runs two stages behind the command bus
    logic        drv_load;
    logic        exp_valid_1;
    logic        exp_valid_2;
    logic [31:0] exp_data;

    int loads_sent = 0;
    int loads_seen = 0;

    mem_subsys i_mem_subsys (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .load_valid (load_valid),
        .load_data  (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    initial begin
        #(timeout_ns);
        report_failure("timeout, the run did not reach its end in time");
    end

    // ========================================================================
    // reference model
    // ========================================================================

    function automatic logic [addr_w-1:0] lane(input int unsigned ea, input int unsigned k);
        return addr_w'((ea + k) % mem_bytes);
    endfunction

    function automatic logic [7:0] fill_byte(input int unsigned a);
        return 8'(a * 37 + 90);
    endfunction

    function automatic logic [31:0] expected_load(input int unsigned ea, input logic is_word,
                                                  input logic is_signed);
        logic [31:0] w;
        logic [7:0]  b;
        w = {ref_mem[lane(ea, 3)], ref_mem[lane(ea, 2)], ref_mem[lane(ea, 1)],
             ref_mem[lane(ea, 0)]};
        b = ref_mem[lane(ea, 0)];
        if (is_word) begin
            return w;
        end
        if (is_signed && b[7]) begin
            return {24'hffffff, b};
        end
        return {24'h000000, b};
    endfunction

    // ========================================================================
    // stimulus
    // ========================================================================

    task automatic send_command(input logic is_store, input logic is_word,
                                input logic is_signed, input logic [31:0] base,
                                input logic [offset_w-1:0] offset, input logic [31:0] wdata);
        logic [31:0] sum;
        int unsigned ea;
        @(negedge clk);
        cmd_valid     = 1'b1;
        cmd.is_store  = is_store;
        cmd.is_word   = is_word;
        cmd.is_signed = is_signed;
        cmd.base      = base;
        cmd.offset    = offset;
        cmd.wdata     = wdata;
        drv_load      = !is_store;
        sum = base + 32'($signed(offset));
        ea  = sum % mem_bytes;
        if (is_store) begin
            ref_mem[lane(ea, 0)] = wdata[7:0];
            if (is_word) begin
                ref_mem[lane(ea, 1)] = wdata[15:8];
                ref_mem[lane(ea, 2)] = wdata[23:16];
                ref_mem[lane(ea, 3)] = wdata[31:24];
            end
        end else begin
            exp_q.push_back(expected_load(ea, is_word, is_signed));
            loads_sent++;
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        cmd_valid = 1'b0;
        drv_load  = 1'b0;
        // a junk store left on the bus must not reach memory
        cmd.is_store = 1'b1;
        cmd.base     = $urandom;
        cmd.wdata    = $urandom;
    endtask

    task automatic store_word(input logic [31:0] base, input logic [offset_w-1:0] offset,
                              input logic [31:0] data);
        send_command(1'b1, 1'b1, 1'b0, base, offset, data);
    endtask

    // upper lanes carry junk that a byte store must ignore
    task automatic store_byte(input logic [31:0] base, input logic [offset_w-1:0] offset,
                              input logic [7:0] data);
        send_command(1'b1, 1'b0, 1'b0, base, offset, {24'heeeeee, data});
    endtask

    task automatic load_word(input logic [31:0] base, input logic [offset_w-1:0] offset);
        send_command(1'b0, 1'b1, 1'b0, base, offset, 32'h0);
    endtask

    task automatic load_byte(input logic [31:0] base, input logic [offset_w-1:0] offset,
                             input logic is_signed);
        send_command(1'b0, 1'b0, is_signed, base, offset, 32'h0);
    endtask

    task automatic random_command();
        int unsigned         kind;
        logic [31:0]         base;
        logic [offset_w-1:0] offset;
        kind   = $urandom % 10;
        base   = $urandom;
        offset = offset_w'($urandom);
        if (kind < 2) begin
            idle_cycle();
        end else if (kind < 5) begin
            send_command(1'b1, 1'($urandom), 1'b0, base, offset, $urandom);
        end else begin
            send_command(1'b0, 1'($urandom), 1'($urandom), base, offset, 32'h0);
        end
    endtask

    // ========================================================================
    // checking
    // ========================================================================

    always @(posedge clk) begin
        if (rst) begin
            exp_valid_1 <= 1'b0;
            exp_valid_2 <= 1'b0;
        end else begin
            exp_valid_1 <= drv_load;
            exp_valid_2 <= exp_valid_1;
            if (exp_valid_1) begin
                exp_data <= exp_q.pop_front();
            end
        end
    end

    always @(negedge clk) begin
        if (load_valid === 1'b1) begin
            loads_seen++;
        end
    end

    valid_matches: assert property (@(posedge clk) disable iff (rst)
        load_valid == exp_valid_2)
        else report_failure($sformatf("mismatch load_valid: got %h expected %h",
                                      $sampled(load_valid), $sampled(exp_valid_2)));

    data_matches: assert property (@(posedge clk) disable iff (rst)
        load_valid |-> load_data == exp_data)
        else report_failure($sformatf("mismatch load_data: got %h expected %h",
                                      $sampled(load_data), $sampled(exp_data)));

    // ========================================================================
    // test sequence
    // ========================================================================

    initial begin
        void'($urandom(seed));
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        drv_load  = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (4) idle_cycle();

        for (int a = 0; a < mem_bytes; a += 4) begin
            store_word(32'(a), 12'h000,
                       {fill_byte(a + 3), fill_byte(a + 2), fill_byte(a + 1), fill_byte(a)});
        end

        store_word(32'd8, 12'h000, 32'h8a3c71f4);
        load_word(32'd8, 12'h000);
        for (int k = 0; k < 4; k++) begin
            load_byte(32'(8 + k), 12'h000, 1'b0);
        end

        // merged word must be visible to a load on the very next cycle
        store_byte(32'd10, 12'h000, 8'hc5);
        load_word(32'd8, 12'h000);
        load_byte(32'd10, 12'h000, 1'b1);
        idle_cycle();

        store_byte(32'd20, 12'h000, 8'h9e);
        store_byte(32'd21, 12'h000, 8'h3b);
        load_byte(32'd20, 12'h000, 1'b0);
        load_byte(32'd20, 12'h000, 1'b1);
        load_byte(32'd21, 12'h000, 1'b1);
        load_byte(32'd21, 12'h000, 1'b0);

        store_byte(32'd5, 12'hffd, 8'ha7);
        load_byte(32'd2, 12'h000, 1'b0);
        store_byte(32'h12345677, 12'h7ff, 8'h61);
        load_byte(32'd22, 12'h000, 1'b1);
        load_word(32'd100, 12'h800);
        load_byte(32'hffffffff, 12'h001, 1'b0);

        // upper lanes of these words fold back to address 0
        store_word(32'd30, 12'h000, 32'hdeadbeef);
        load_word(32'd30, 12'h000);
        for (int k = 0; k < 4; k++) begin
            load_byte(32'(30 + k), 12'h000, 1'b1);
        end
        load_word(32'd29, 12'h000);
        load_word(32'd31, 12'h000);
        store_word(32'd61, 12'h000, 32'h0badf00d);
        load_word(32'd29, 12'h000);
        repeat (2) idle_cycle();

        repeat (random_cmds) random_command();

        repeat (4) idle_cycle();
        @(posedge clk);
        if (loads_seen != loads_sent) begin
            report_failure($sformatf("%0d loads were issued but %0d results came back",
                                     loads_sent, loads_seen));
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule
